//--- logic/pif_defines.svh
`ifndef PIF_DEFINES_SVH
`define PIF_DEFINES_SVH

// received byte layout, tag over payload
`define PIF_DATA_BITS 6
`define PIF_TAG_BITS 2
`define PIF_TAG_ADDR 2'd1
`define PIF_TAG_DATA 2'd2

// peripheral-interface field widths
`define PIF_ADDR_BITS 4
`define PIF_SUBA_BITS 7

// ---------------------------------------------------------------------------
// I2C controller register map on the Wishbone side
// ---------------------------------------------------------------------------
`define I2C_CMDR 8'h41
`define I2C_TXDR 8'h44
`define I2C_SR 8'h45
`define I2C_RXDR 8'h47

// command register values
`define CMD_STRETCH_OFF 8'h04
`define CMD_STRETCH_ON 8'h00

// internal reset length in clocks
`define RST_STRETCH_CLKS 16

`endif

//--- logic/pifPkg.sv
`include "pif_defines.svh"

package pifPkg;

    // status register, msb first
    typedef struct packed {
        logic tip;
        logic busy;
        logic rarc;
        logic srw;
        logic arbl;
        logic trrdy;
        logic troe;
        logic hgc;
    } srBits_t;

    // peripheral-interface fields
    typedef logic [`PIF_DATA_BITS-1:0] pifData_t;
    typedef logic [`PIF_ADDR_BITS-1:0] pifAddr_t;
    typedef logic [`PIF_SUBA_BITS-1:0] pifSubAddr_t;

    // receive register, tag in the top bits
    typedef struct packed {
        logic [`PIF_TAG_BITS-1:0] tag;
        pifData_t payload;
    } rxFrame_t;

    // ------------------------------------------------------------------------
    // one bus read word, seen as status or as receive frame
    // ------------------------------------------------------------------------
    typedef union packed {
        srBits_t sr;
        rxFrame_t rx;
    } busWord_u;

endpackage

//--- logic/wbReqIf.sv
`timescale 1ns/1ns

interface wbReqIf
    import pifPkg::*;
();

    // request side, req is a one-clock strobe
    logic req;
    logic we;
    logic [7:0] addr;
    logic [7:0] wrData;

    // completion, rdData valid with done
    logic done;
    busWord_u rdData;

    modport seq (
        output req, we, addr, wrData,
        input done, rdData
    );

    modport bus (
        input req, we, addr, wrData,
        output done, rdData
    );

endinterface

//--- logic/wbMasterCycle.sv
`timescale 1ns/1ns

module wbMasterCycle
    import pifPkg::*;
(
    input logic xclk_i,
    input logic sys_rst_i,
    wbReqIf.bus bus,
    output logic wbCyc_o,
    output logic wbStb_o,
    output logic wbWe_o,
    output logic [7:0] wbAdr_o,
    output logic [7:0] wbDat_o,
    input logic [7:0] wbDat_i,
    input logic wbAck_i
);

    logic cycActive;
    logic doneQ;
    busWord_u rdQ;

    // one classic cycle per request, held until ack
    always_ff @(posedge xclk_i or negedge sys_rst_i) begin
        if (!sys_rst_i) begin
            cycActive <= 1'b0;
            wbWe_o <= 1'b0;
            wbAdr_o <= '0;
            doneQ <= 1'b0;
        end else begin
            doneQ <= 1'b0;
            if (!cycActive) begin
                if (bus.req) begin
                    cycActive <= 1'b1;
                    wbWe_o <= bus.we;
                    wbAdr_o <= bus.addr;
                end
            end else if (wbAck_i) begin
                cycActive <= 1'b0;
                wbWe_o <= 1'b0;
                doneQ <= 1'b1;
            end
        end
    end

    // write data and read capture
    always_ff @(posedge xclk_i) begin
        if (!cycActive && bus.req) begin
            wbDat_o <= bus.wrData;
        end
        if (cycActive && wbAck_i) begin
            rdQ <= busWord_u'(wbDat_i);
        end
    end

    assign wbCyc_o = cycActive;
    assign wbStb_o = cycActive;
    assign bus.done = doneQ;
    assign bus.rdData = rdQ;

endmodule

//--- logic/i2cSlaveSequencer.sv
`timescale 1ns/1ns
`include "pif_defines.svh"

module i2cSlaveSequencer
    import pifPkg::*;
(
    input logic xclk_i,
    input logic sys_rst_i,
    wbReqIf.seq seq,
    input logic [7:0] txByte_i,
    output logic frameValid_o,
    output rxFrame_t frame_o,
    output logic txDone_o
);

    localparam int RstCntBits = $clog2(`RST_STRETCH_CLKS + 1);

    typedef enum logic [3:0] {
        StStart,
        StInit1,
        StInit2,
        StInit3,
        StInit4,
        StIdle,
        StWaitTr,
        StIn,
        StOut,
        StPend
    } seqState_t;

    seqState_t state, nextState;
    seqState_t retState, nextRet;

    logic [RstCntBits-1:0] rstCnt;
    logic rstStretch;

    logic issue;
    logic issueWe;
    logic [7:0] issueAddr;
    logic [7:0] issueData;

    logic reqQ;
    logic weQ;
    logic [7:0] addrQ;
    logic [7:0] wrDataQ;

    srBits_t srQ;
    rxFrame_t rxQ;
    logic txReady;
    logic rxReady;
    logic lastNak;

    // ------------------------------------------------------------------------
    // internal reset, held for a fixed number of clocks
    // ------------------------------------------------------------------------
    always_ff @(posedge xclk_i or negedge sys_rst_i) begin
        if (!sys_rst_i) begin
            rstCnt <= '0;
        end else if (rstStretch) begin
            rstCnt <= rstCnt + 1'b1;
        end
    end

    assign rstStretch = (rstCnt != RstCntBits'(`RST_STRETCH_CLKS));

    // status decode of the last SR read
    assign txReady = srQ.busy & srQ.trrdy & srQ.srw & ~srQ.tip;
    assign rxReady = srQ.busy & srQ.trrdy & ~srQ.srw;
    assign lastNak = srQ.busy & srQ.rarc & srQ.srw & srQ.troe;

    // ------------------------------------------------------------------------
    // service FSM, every bus access goes through the pending state
    // ------------------------------------------------------------------------
    always_comb begin
        nextState = state;
        nextRet = retState;
        issue = 1'b0;
        issueWe = 1'b0;
        issueAddr = `I2C_SR;
        issueData = 8'h00;
        case (state)
            StStart: begin
                if (!rstStretch) begin
                    issue = 1'b1;
                    issueWe = 1'b1;
                    issueAddr = `I2C_CMDR;
                    issueData = `CMD_STRETCH_OFF;
                    nextRet = StInit1;
                end
            end
            StInit1: begin
                issue = 1'b1;
                nextRet = StInit2;
            end
            StInit2: begin
                // keep polling until the controller is idle
                issue = 1'b1;
                if (srQ.busy) begin
                    nextRet = StInit2;
                end else begin
                    issueAddr = `I2C_RXDR;
                    nextRet = StInit3;
                end
            end
            StInit3: begin
                issue = 1'b1;
                issueAddr = `I2C_RXDR;
                nextRet = StInit4;
            end
            StInit4: begin
                issue = 1'b1;
                issueWe = 1'b1;
                issueAddr = `I2C_CMDR;
                issueData = `CMD_STRETCH_ON;
                nextRet = StIdle;
            end
            StIdle: begin
                // status is cleared by any non-SR access
                if (srQ.busy) begin
                    nextState = StWaitTr;
                end else begin
                    issue = 1'b1;
                    nextRet = StIdle;
                end
            end
            StWaitTr: begin
                if (lastNak) begin
                    nextState = StStart;
                end else if (txReady) begin
                    issue = 1'b1;
                    issueWe = 1'b1;
                    issueAddr = `I2C_TXDR;
                    issueData = txByte_i;
                    nextRet = StOut;
                end else if (rxReady) begin
                    issue = 1'b1;
                    issueAddr = `I2C_RXDR;
                    nextRet = StIn;
                end else if (!srQ.busy) begin
                    nextState = StStart;
                end else begin
                    issue = 1'b1;
                    nextRet = StWaitTr;
                end
            end
            StIn: nextState = StIdle;
            StOut: nextState = StIdle;
            StPend: begin
                if (seq.done) begin
                    nextState = retState;
                end
            end
            default: nextState = StStart;
        endcase
        if (issue) begin
            nextState = StPend;
        end
    end

    always_ff @(posedge xclk_i or negedge sys_rst_i) begin
        if (!sys_rst_i) begin
            state <= StStart;
            retState <= StStart;
            reqQ <= 1'b0;
            weQ <= 1'b0;
            srQ <= '0;
        end else begin
            state <= nextState;
            retState <= nextRet;
            reqQ <= issue;
            if (issue) begin
                weQ <= issueWe;
            end
            if (seq.done) begin
                srQ <= (addrQ == `I2C_SR) ? seq.rdData.sr : '0;
            end
        end
    end

    // request payload and received frame
    always_ff @(posedge xclk_i) begin
        if (issue) begin
            addrQ <= issueAddr;
            wrDataQ <= issueData;
        end
        if (seq.done && addrQ == `I2C_RXDR) begin
            rxQ <= seq.rdData.rx;
        end
    end

    assign seq.req = reqQ;
    assign seq.we = weQ;
    assign seq.addr = addrQ;
    assign seq.wrData = wrDataQ;

    assign frameValid_o = (state == StIn);
    assign frame_o = rxQ;
    assign txDone_o = (state == StOut);

endmodule

//--- logic/pifPortDecoder.sv
`timescale 1ns/1ns
`include "pif_defines.svh"

module pifPortDecoder
    import pifPkg::*;
(
    input logic xclk_i,
    input logic sys_rst_i,
    input logic frameValid_i,
    input rxFrame_t frame_i,
    input logic txDone_i,
    output logic xiPWr_o,
    output logic xiPRdFinished_o,
    output pifAddr_t xiPRWA_o,
    output pifSubAddr_t xiPRdSubA_o,
    output pifData_t xiPD_o
);

    logic isAddr;
    logic isData;
    pifAddr_t rwAddr;
    pifSubAddr_t rdSubAddr;
    pifData_t inData;
    logic pWrQ;
    logic rdFinQ;

    // tag classification, other tags drop out here
    assign isAddr = frameValid_i && (frame_i.tag == `PIF_TAG_ADDR);
    assign isData = frameValid_i && (frame_i.tag == `PIF_TAG_DATA);

    // ------------------------------------------------------------------------
    // first stage
    // ------------------------------------------------------------------------
    always_ff @(posedge xclk_i or negedge sys_rst_i) begin
        if (!sys_rst_i) begin
            rwAddr <= '0;
            rdSubAddr <= '0;
            pWrQ <= 1'b0;
            rdFinQ <= 1'b0;
        end else begin
            pWrQ <= isData;
            rdFinQ <= txDone_i;
            if (isAddr) begin
                rwAddr <= frame_i.payload[`PIF_ADDR_BITS-1:0];
                rdSubAddr <= '0;
            end else if (txDone_i) begin
                // 7-bit counter wraps at 128
                rdSubAddr <= rdSubAddr + 1'b1;
            end
        end
    end

    // ------------------------------------------------------------------------
    // output stage
    // ------------------------------------------------------------------------
    always_ff @(posedge xclk_i or negedge sys_rst_i) begin
        if (!sys_rst_i) begin
            xiPWr_o <= 1'b0;
            xiPRdFinished_o <= 1'b0;
            xiPRWA_o <= '0;
            xiPRdSubA_o <= '0;
        end else begin
            xiPWr_o <= pWrQ;
            xiPRdFinished_o <= rdFinQ;
            xiPRWA_o <= rwAddr;
            xiPRdSubA_o <= rdSubAddr;
        end
    end

    // data path
    always_ff @(posedge xclk_i) begin
        if (isData) begin
            inData <= frame_i.payload;
        end
        xiPD_o <= inData;
    end

endmodule

//--- logic/pifWbTop.sv
`timescale 1ns/1ns

module pifWbTop
    import pifPkg::*;
(
    input logic xclk_i,
    input logic sys_rst_i,
    output logic wbCyc_o,
    output logic wbStb_o,
    output logic wbWe_o,
    output logic [7:0] wbAdr_o,
    output logic [7:0] wbDat_o,
    input logic [7:0] wbDat_i,
    input logic wbAck_i,
    input logic [7:0] txByte_i,
    output logic xiPWr_o,
    output logic xiPRdFinished_o,
    output pifAddr_t xiPRWA_o,
    output pifSubAddr_t xiPRdSubA_o,
    output pifData_t xiPD_o
);

    // sequencer to decoder
    logic frameValid;
    rxFrame_t frame;
    logic txDone;

    // single outstanding bus request
    wbReqIf busReq ();

    wbMasterCycle i_wbMasterCycle (
        .xclk_i(xclk_i),
        .sys_rst_i(sys_rst_i),
        .bus(busReq.bus),
        .wbCyc_o(wbCyc_o),
        .wbStb_o(wbStb_o),
        .wbWe_o(wbWe_o),
        .wbAdr_o(wbAdr_o),
        .wbDat_o(wbDat_o),
        .wbDat_i(wbDat_i),
        .wbAck_i(wbAck_i)
    );

    i2cSlaveSequencer i_i2cSlaveSequencer (
        .xclk_i(xclk_i),
        .sys_rst_i(sys_rst_i),
        .seq(busReq.seq),
        .txByte_i(txByte_i),
        .frameValid_o(frameValid),
        .frame_o(frame),
        .txDone_o(txDone)
    );

    pifPortDecoder i_pifPortDecoder (
        .xclk_i(xclk_i),
        .sys_rst_i(sys_rst_i),
        .frameValid_i(frameValid),
        .frame_i(frame),
        .txDone_i(txDone),
        .xiPWr_o(xiPWr_o),
        .xiPRdFinished_o(xiPRdFinished_o),
        .xiPRWA_o(xiPRWA_o),
        .xiPRdSubA_o(xiPRdSubA_o),
        .xiPD_o(xiPD_o)
    );

endmodule

//--- verification/efbSlaveModel.sv
`timescale 1ns/1ns
`include "pif_defines.svh"

module efbSlaveModel #(
    parameter int Seed = 82666
) (
    input logic xclk_i,
    input logic sys_rst_i,
    input logic wbCyc_i,
    input logic wbStb_i,
    input logic wbWe_i,
    input logic [7:0] wbAdr_i,
    input logic [7:0] wbDat_i,
    output logic [7:0] wbDat_o,
    output logic wbAck_o
);

    // scripted answers for SR and RXDR reads
    logic [7:0] statusQ[$];
    logic [7:0] rxQ[$];

    // every finished cycle as {we, address, data}
    logic [16:0] cycleLog[$];

    int seed;
    int waitCnt;
    bit pending;
    logic [7:0] rdByte;

    function automatic void pushStatus(input logic [7:0] sr);
        statusQ.push_back(sr);
    endfunction

    function automatic void pushRx(input logic [7:0] rx);
        rxQ.push_back(rx);
    endfunction

    function automatic int scriptLeft();
        return statusQ.size() + rxQ.size();
    endfunction

    function automatic int logSize();
        return cycleLog.size();
    endfunction

    function automatic logic [16:0] logEntry(input int idx);
        return cycleLog[idx];
    endfunction

    // ------------------------------------------------------------------------
    // classic slave, ack after 1 to 3 clocks
    // ------------------------------------------------------------------------
    initial begin
        seed = Seed;
        pending = 1'b0;
        waitCnt = 0;
        wbAck_o = 1'b0;
        wbDat_o = 8'h00;
        forever begin
            @(posedge xclk_i);
            if (!sys_rst_i) begin
                pending = 1'b0;
            end else if (wbAck_o) begin
                // master takes ack on this edge
                #1;
                wbAck_o = 1'b0;
            end else if (wbCyc_i && wbStb_i) begin
                if (!pending) begin
                    pending = 1'b1;
                    waitCnt = 1 + ({$random(seed)} % 3);
                end
                waitCnt = waitCnt - 1;
                if (waitCnt == 0) begin
                    pending = 1'b0;
                    // empty status queue reads as not busy
                    rdByte = 8'h00;
                    if (!wbWe_i && wbAdr_i == `I2C_SR && statusQ.size() > 0) begin
                        rdByte = statusQ.pop_front();
                    end else if (!wbWe_i && wbAdr_i == `I2C_RXDR && rxQ.size() > 0) begin
                        rdByte = rxQ.pop_front();
                    end
                    cycleLog.push_back({wbWe_i, wbAdr_i, wbWe_i ? wbDat_i : rdByte});
                    #1;
                    wbDat_o = rdByte;
                    wbAck_o = 1'b1;
                end
            end
        end
    end

endmodule

//--- verification/pifWbAsserts.sv
`timescale 1ns/1ns

module pifWbAsserts (
    input logic xclk_i,
    input logic sys_rst_i,
    input logic wbCyc_i,
    input logic wbStb_i,
    input logic wbWe_i,
    input logic [7:0] wbAdr_i,
    input logic [7:0] wbDat_i,
    input logic wbAck_i,
    input logic xiPWr_i,
    input logic xiPRdFinished_i
);

    // classic cycle closes in the clock after ack
    cycEnd: assert property (@(posedge xclk_i) disable iff (!sys_rst_i)
        (wbStb_i && wbAck_i) |=> (!wbStb_i && !wbCyc_i))
        else $error("wbCyc_o or wbStb_o still high after ack");

    // request held until the slave answers
    reqStable: assert property (@(posedge xclk_i) disable iff (!sys_rst_i)
        (wbStb_i && !wbAck_i) |=> ($stable(wbAdr_i) && $stable(wbDat_i) && $stable(wbWe_i)))
        else $error("address, data or we changed before ack");

    wrOneCycle: assert property (@(posedge xclk_i) disable iff (!sys_rst_i)
        xiPWr_i |=> !xiPWr_i)
        else $error("xiPWr_o wider than one clock");

    finOneCycle: assert property (@(posedge xclk_i) disable iff (!sys_rst_i)
        xiPRdFinished_i |=> !xiPRdFinished_i)
        else $error("xiPRdFinished_o wider than one clock");

endmodule

bind pifWbTop pifWbAsserts i_pifWbAsserts (
    .xclk_i(xclk_i),
    .sys_rst_i(sys_rst_i),
    .wbCyc_i(wbCyc_o),
    .wbStb_i(wbStb_o),
    .wbWe_i(wbWe_o),
    .wbAdr_i(wbAdr_o),
    .wbDat_i(wbDat_o),
    .wbAck_i(wbAck_i),
    .xiPWr_i(xiPWr_o),
    .xiPRdFinished_i(xiPRdFinished_o)
);

//--- verification/pifWbTb.sv
`timescale 1ns/1ns
`include "pif_defines.svh"

module pifWbTb
    import pifPkg::*;
();

    localparam int NumTests = 5;
    localparam int CyclesPerTest = 3000;
    localparam int ClkPeriod = 10;
    localparam int WatchdogNs = NumTests * CyclesPerTest * ClkPeriod;
    localparam int WaitLimit = 400;
    localparam int NumTx = 130;

    // what waitFor watches
    localparam int WaitWrites = 0;
    localparam int WaitWrPulse = 1;
    localparam int WaitFinPulse = 2;
    localparam int WaitDrained = 3;

    // busy and ready with the slave receiving
    localparam logic [7:0] StRxReady = 8'h44;
    // busy and ready with the slave transmitting
    localparam logic [7:0] StTxReady = 8'h54;
    // busy, nak, slave transmitting and overrun
    localparam logic [7:0] StNak = 8'h72;
    localparam logic [7:0] StBusy = 8'h40;
    localparam logic [7:0] StFree = 8'h00;

    logic xclk;
    logic sys_rst;
    logic wbCyc;
    logic wbStb;
    logic wbWe;
    logic [7:0] wbAdr;
    logic [7:0] wbDatW;
    logic [7:0] wbDatR;
    logic wbAck;
    logic [7:0] txByte;
    logic xiPWr;
    logic xiPRdFinished;
    pifAddr_t xiPRWA;
    pifSubAddr_t xiPRdSubA;
    pifData_t xiPD;

    int seed;
    int errors = 0;
    int checks = 0;
    int testErrors = 0;
    int testsRun = 0;
    int wrPulses = 0;
    int finPulses = 0;

    // reference state of the decoder outputs
    pifAddr_t expAddr = '0;
    pifSubAddr_t expSubA = '0;

    pifWbTop i_pifWbTop (
        .xclk_i(xclk),
        .sys_rst_i(sys_rst),
        .wbCyc_o(wbCyc),
        .wbStb_o(wbStb),
        .wbWe_o(wbWe),
        .wbAdr_o(wbAdr),
        .wbDat_o(wbDatW),
        .wbDat_i(wbDatR),
        .wbAck_i(wbAck),
        .txByte_i(txByte),
        .xiPWr_o(xiPWr),
        .xiPRdFinished_o(xiPRdFinished),
        .xiPRWA_o(xiPRWA),
        .xiPRdSubA_o(xiPRdSubA),
        .xiPD_o(xiPD)
    );

    efbSlaveModel i_efbSlaveModel (
        .xclk_i(xclk),
        .sys_rst_i(sys_rst),
        .wbCyc_i(wbCyc),
        .wbStb_i(wbStb),
        .wbWe_i(wbWe),
        .wbAdr_i(wbAdr),
        .wbDat_i(wbDatW),
        .wbDat_o(wbDatR),
        .wbAck_o(wbAck)
    );

    always #(ClkPeriod / 2) xclk = ~xclk;

    // strobe counters
    always @(posedge xclk) begin
        if (xiPWr) begin
            wrPulses = wrPulses + 1;
        end
        if (xiPRdFinished) begin
            finPulses = finPulses + 1;
        end
    end

    // ------------------------------------------------------------------------
    // compare tasks and helpers
    // ------------------------------------------------------------------------
    task automatic reportFail(input string msg);
        $display("FAIL t=%0t %s", $time, msg);
        errors = errors + 1;
    endtask

    task automatic checkByte(input string what, input logic [7:0] got, input logic [7:0] exp);
        checks = checks + 1;
        if (got !== exp) begin
            reportFail($sformatf("%s got %02h expected %02h", what, got, exp));
        end
    endtask

    task automatic checkAddr(input string what, input pifAddr_t got, input pifAddr_t exp);
        checks = checks + 1;
        if (got !== exp) begin
            reportFail($sformatf("%s got %0h expected %0h", what, got, exp));
        end
    endtask

    task automatic checkSubAddr(input string what, input pifSubAddr_t got,
                                input pifSubAddr_t exp);
        checks = checks + 1;
        if (got !== exp) begin
            reportFail($sformatf("%s got %0d expected %0d", what, got, exp));
        end
    endtask

    task automatic checkData(input string what, input pifData_t got, input pifData_t exp);
        checks = checks + 1;
        if (got !== exp) begin
            reportFail($sformatf("%s got %02h expected %02h", what, got, exp));
        end
    endtask

    function automatic int countWrites();
        int n;
        n = 0;
        for (int i = 0; i < i_efbSlaveModel.logSize(); i++) begin
            if (i_efbSlaveModel.logEntry(i) & 17'h10000) begin
                n = n + 1;
            end
        end
        return n;
    endfunction

    // k-th logged write as {address, data}, zero if missing
    function automatic logic [15:0] writeAt(input int k);
        logic [16:0] entry;
        int n;
        n = 0;
        for (int i = 0; i < i_efbSlaveModel.logSize(); i++) begin
            entry = i_efbSlaveModel.logEntry(i);
            if (entry[16]) begin
                if (n == k) begin
                    return entry[15:0];
                end
                n = n + 1;
            end
        end
        return 16'h0000;
    endfunction

    function automatic int progressOf(input int kind);
        case (kind)
            WaitWrites: return countWrites();
            WaitWrPulse: return wrPulses;
            WaitFinPulse: return finPulses;
            default: return (i_efbSlaveModel.scriptLeft() == 0) ? 1 : 0;
        endcase
    endfunction

    task automatic waitFor(input string what, input int kind, input int target);
        int n;
        n = 0;
        while (progressOf(kind) < target && n < WaitLimit) begin
            @(posedge xclk);
            #1;
            n = n + 1;
        end
        if (progressOf(kind) < target) begin
            $display("timeout at %0t: %s did not happen within %0d cycles",
                     $time, what, WaitLimit);
            errors = errors + 1;
        end
    endtask

    task automatic idleCycles(input int n);
        repeat (n) begin
            @(posedge xclk);
            #1;
        end
    endtask

    task automatic finishTest(input string name);
        testsRun = testsRun + 1;
        $display("test %s finished with %0d error(s)", name, errors - testErrors);
    endtask

    // ------------------------------------------------------------------------
    // directed tests
    // ------------------------------------------------------------------------
    task automatic testInit();
        logic [16:0] entry;
        logic [15:0] wr;
        int writesSeen;
        int srReads;
        int rxReads;
        int i;
        testErrors = errors;
        writesSeen = 0;
        srReads = 0;
        rxReads = 0;
        i = 0;
        waitFor("the two initialisation writes", WaitWrites, 2);
        // count reads between the two command writes
        while (i < i_efbSlaveModel.logSize() && writesSeen < 2) begin
            entry = i_efbSlaveModel.logEntry(i);
            if (entry[16]) begin
                writesSeen = writesSeen + 1;
            end else if (writesSeen == 1 && entry[15:8] == `I2C_SR) begin
                srReads = srReads + 1;
            end else if (writesSeen == 1 && entry[15:8] == `I2C_RXDR) begin
                rxReads = rxReads + 1;
            end
            i = i + 1;
        end
        wr = writeAt(0);
        checkByte("first write address", wr[15:8], `I2C_CMDR);
        checkByte("first write data", wr[7:0], `CMD_STRETCH_OFF);
        wr = writeAt(1);
        checkByte("second write address", wr[15:8], `I2C_CMDR);
        checkByte("second write data", wr[7:0], `CMD_STRETCH_ON);
        if (srReads == 0) begin
            reportFail("no SR read between the initialisation writes");
        end
        checkByte("RXDR reads during initialisation", 8'(rxReads), 8'd2);
        finishTest("init");
    endtask

    task automatic testAddrData();
        rxFrame_t fr;
        pifData_t addrPay;
        pifData_t dataPay;
        int base;
        testErrors = errors;
        addrPay = pifData_t'($random(seed));
        dataPay = pifData_t'($random(seed));
        // new address must differ from the current one
        if (addrPay[`PIF_ADDR_BITS-1:0] == expAddr) begin
            addrPay[0] = ~addrPay[0];
        end
        base = wrPulses;
        fr.tag = `PIF_TAG_ADDR;
        fr.payload = addrPay;
        i_efbSlaveModel.pushStatus(StRxReady);
        i_efbSlaveModel.pushRx(fr);
        fr.tag = `PIF_TAG_DATA;
        fr.payload = dataPay;
        i_efbSlaveModel.pushStatus(StRxReady);
        i_efbSlaveModel.pushRx(fr);
        waitFor("xiPWr_o pulse", WaitWrPulse, base + 1);
        waitFor("script drained", WaitDrained, 1);
        idleCycles(20);
        // an address frame clears the sub-address
        expAddr = addrPay[`PIF_ADDR_BITS-1:0];
        expSubA = '0;
        checkByte("xiPWr_o pulses", 8'(wrPulses - base), 8'd1);
        checkAddr("xiPRWA_o", xiPRWA, expAddr);
        checkSubAddr("xiPRdSubA_o", xiPRdSubA, expSubA);
        checkData("xiPD_o", xiPD, dataPay);
        finishTest("addrThenData");
    endtask

    task automatic testTransmit();
        logic [7:0] tx;
        logic [15:0] wr;
        int wBase;
        int fBase;
        int finStart;
        testErrors = errors;
        finStart = finPulses;
        for (int k = 0; k < NumTx; k++) begin
            tx = 8'($random(seed));
            txByte = tx;
            wBase = countWrites();
            fBase = finPulses;
            i_efbSlaveModel.pushStatus(StTxReady);
            waitFor("TXDR write", WaitWrites, wBase + 1);
            wr = writeAt(wBase);
            checkByte("TXDR write address", wr[15:8], `I2C_TXDR);
            checkByte("TXDR write data", wr[7:0], tx);
            waitFor("xiPRdFinished_o pulse", WaitFinPulse, fBase + 1);
        end
        idleCycles(10);
        // read sub-address wraps at 128
        expSubA = pifSubAddr_t'((int'(expSubA) + NumTx) % 128);
        checkByte("xiPRdFinished_o pulses", 8'(finPulses - finStart), 8'(NumTx));
        checkSubAddr("xiPRdSubA_o", xiPRdSubA, expSubA);
        finishTest("slaveTransmit");
    endtask

    task automatic testUnknownTag();
        rxFrame_t fr;
        int base;
        testErrors = errors;
        base = wrPulses;
        fr.tag = 2'd0;
        fr.payload = pifData_t'($random(seed));
        fr.payload[`PIF_ADDR_BITS-1:0] = ~expAddr;
        i_efbSlaveModel.pushStatus(StRxReady);
        i_efbSlaveModel.pushRx(fr);
        fr.tag = 2'd3;
        i_efbSlaveModel.pushStatus(StRxReady);
        i_efbSlaveModel.pushRx(fr);
        waitFor("script drained", WaitDrained, 1);
        idleCycles(20);
        checkByte("xiPWr_o pulses", 8'(wrPulses - base), 8'd0);
        checkAddr("xiPRWA_o", xiPRWA, expAddr);
        finishTest("unknownTag");
    endtask

    task automatic testTermination();
        logic [15:0] wr;
        int wBase;
        testErrors = errors;
        // nak from the master ends the transfer
        wBase = countWrites();
        i_efbSlaveModel.pushStatus(StNak);
        waitFor("restart after NAK", WaitWrites, wBase + 2);
        wr = writeAt(wBase);
        checkByte("write after NAK address", wr[15:8], `I2C_CMDR);
        checkByte("write after NAK data", wr[7:0], `CMD_STRETCH_OFF);
        wr = writeAt(wBase + 1);
        checkByte("re-init second write data", wr[7:0], `CMD_STRETCH_ON);
        // bus goes idle while waiting
        wBase = countWrites();
        i_efbSlaveModel.pushStatus(StBusy);
        i_efbSlaveModel.pushStatus(StFree);
        waitFor("restart after bus idle", WaitWrites, wBase + 2);
        wr = writeAt(wBase);
        checkByte("write after bus idle address", wr[15:8], `I2C_CMDR);
        checkByte("write after bus idle data", wr[7:0], `CMD_STRETCH_OFF);
        finishTest("termination");
    endtask

    // ------------------------------------------------------------------------
    // watchdog and main sequence
    // ------------------------------------------------------------------------
    initial begin
        #(WatchdogNs);
        $display("watchdog expired after %0d ns, tests did not complete", WatchdogNs);
        $display("Regression failed");
        $finish;
    end

    initial begin
        seed = 82666;
        xclk = 1'b0;
        sys_rst = 1'b0;
        txByte = 8'h00;
        repeat (4) @(posedge xclk);
        #1;
        sys_rst = 1'b1;
        testInit();
        // transmit first so the address frame has a sub-address to clear
        testTransmit();
        testAddrData();
        testUnknownTag();
        testTermination();
        $display("%0d tests, %0d checks, %0d errors", testsRun, checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- compile.f
+incdir+logic
logic/pifPkg.sv
logic/wbReqIf.sv
logic/wbMasterCycle.sv
logic/i2cSlaveSequencer.sv
logic/pifPortDecoder.sv
logic/pifWbTop.sv
verification/efbSlaveModel.sv
verification/pifWbAsserts.sv
verification/pifWbTb.sv

//--- Makefile
TOOL     := verilator
FLAGS    := --binary --timing --assert --timescale 1ns/1ns -j 0
TOP      := pifWbTb
FILELIST := compile.f
BUILD    := obj_dir
LOG      := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build $(TOP) with $(TOOL) and run the regression"
	@echo "  clean  remove the build folder and the log"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q "Regression failed" $(LOG); then \
		echo "simulation reported failure"; \
		exit 1; \
	fi
	@grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
